// ==== sim.f ====
verilog/axi_pkg.sv
verilog/sys_bus_pkg.sv
verilog/axi_sys_bridge.sv
verilog/sys_bus_decoder.sv
verilog/sys_config_regs.sv
verilog/sys_wait_mem.sv
verilog/axi_sys_top.sv
bench/axi_sys_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the axi register subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   -f sim.f --top-module axi_sys_tb -Mdir obj_dir -o axi_sys_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/axi_sys_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== bench/axi_sys_tb.sv ====
//////////////////////////////////////////////////
// testbench for the axi register subsystem
// drives single beat axi writes and reads,
// checks every b and r beat against a model of
// the config block and the wait memory
//////////////////////////////////////////////////

module axi_sys_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_cycles = 20000;   // ~200 txns x (timeout + wait + stalls)

   logic axi = 1'b0;
   logic reset;
   axi_pkg::aw_chan_t aw;
   axi_pkg::w_chan_t  w;
   axi_pkg::ar_chan_t ar;
   axi_pkg::b_chan_t  b;
   axi_pkg::r_chan_t  r;
   logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
   logic b_valid, b_ready, r_valid, r_ready;

   // expected responses, in issue order
   axi_pkg::b_chan_t exp_b[$];
   axi_pkg::r_chan_t exp_r[$];

   // reference state
   axi_pkg::axi_data_t     mem_m [sys_bus_pkg::mem_words];
   axi_pkg::axi_data_t     scratch_m;
   sys_bus_pkg::mem_wait_t wait_m;

   int   cycle_cnt = 0;
   logic stall_en = 1'b0;
   logic ready_state = 1'b1;
   int   stall_left = 0;
   logic b_held = 1'b0, r_held = 1'b0;
   axi_pkg::b_chan_t b_prev;
   axi_pkg::r_chan_t r_prev;

   axi_sys_top DUT (.*);

   always #4 axi = ~axi;   // 8 ns period

   //////////////////////////////////////////////////
   // failure reporting and compare tasks

   task automatic stop_run();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_failure(input string why);
      $display("%0t: %s", $time, why);
      stop_run();
   endtask

   task automatic check_resp(input string name, input axi_pkg::axi_resp_t got,
                             input axi_pkg::axi_resp_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_data(input string name, input axi_pkg::axi_data_t got,
                             input axi_pkg::axi_data_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_id(input string name, input axi_pkg::axi_id_t got,
                           input axi_pkg::axi_id_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
         stop_run();
      end
   endtask

   //////////////////////////////////////////////////
   // reference model of the address map

   function automatic axi_pkg::axi_resp_t ref_access(
         input bit is_wr, input axi_pkg::axi_addr_t addr, input axi_pkg::axi_len_t len,
         input axi_pkg::axi_size_t size, input axi_pkg::axi_data_t wdata,
         output axi_pkg::axi_data_t rdata);
      axi_pkg::axi_addr_t off;
      rdata = '0;
      off = addr - sys_bus_pkg::mem_base;
      if (len != 4'd0 || size != 3'd2) return axi_pkg::resp_slverr;   // burst or narrow
      if (addr < 32'h10) begin                  // config words 0..3
         case (addr[3:2])
            2'd0: if (!is_wr) rdata = sys_bus_pkg::cfg_id_value;
            2'd1: begin
               if (is_wr) scratch_m = wdata;
               else rdata = scratch_m;
            end
            2'd2: begin
               if (is_wr) wait_m = wdata[3:0];
               else rdata = {28'd0, wait_m};
            end
            default: rdata = '0;
         endcase
         return axi_pkg::resp_okay;
      end
      if (off < 32'h400) begin                  // 256 memory words
         if (is_wr) mem_m[off[9:2]] = wdata;
         else rdata = mem_m[off[9:2]];
         return axi_pkg::resp_okay;
      end
      return axi_pkg::resp_slverr;              // unmapped, ack never comes
   endfunction

   //////////////////////////////////////////////////
   // handshake helpers, entered just after a falling edge

   task automatic finish_aw();
      #1;
      while (!aw_ready) begin
         @(negedge axi);
         #1;
      end
      @(negedge axi);
      aw_valid = 1'b0;
   endtask

   task automatic finish_w();
      #1;
      while (!w_ready) begin
         @(negedge axi);
         #1;
      end
      @(negedge axi);
      w_valid = 1'b0;
   endtask

   task automatic finish_ar();
      #1;
      while (!ar_ready) begin
         @(negedge axi);
         #1;
      end
      @(negedge axi);
      ar_valid = 1'b0;
   endtask

   task automatic wait_responses();
      while (exp_b.size() != 0 || exp_r.size() != 0) @(negedge axi);
   endtask

   task automatic do_write(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                           input axi_pkg::axi_data_t data, input axi_pkg::axi_len_t len = 4'd0,
                           input axi_pkg::axi_size_t size = 3'd2);
      axi_pkg::axi_data_t unused;
      axi_pkg::b_chan_t   exp;
      exp.id   = id;
      exp.resp = ref_access(1'b1, addr, len, size, data, unused);
      exp_b.push_back(exp);
      @(negedge axi);
      aw       = '{id: id, addr: addr, len: len, size: size};
      aw_valid = 1'b1;
      finish_aw();
      w       = '{id: id, data: data};   // bad writes still send the beat
      w_valid = 1'b1;
      finish_w();
      wait_responses();
   endtask

   task automatic do_read(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                          input axi_pkg::axi_len_t len = 4'd0,
                          input axi_pkg::axi_size_t size = 3'd2);
      axi_pkg::axi_data_t d;
      axi_pkg::r_chan_t   exp;
      exp.resp = ref_access(1'b0, addr, len, size, '0, d);
      exp.id   = id;
      exp.data = d;
      exp.last = 1'b1;
      exp_r.push_back(exp);
      @(negedge axi);
      ar       = '{id: id, addr: addr, len: len, size: size};
      ar_valid = 1'b1;
      finish_ar();
      wait_responses();
   endtask

   // aw and ar raised together, write must go first
   task automatic write_read_race(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_data_t data);
      axi_pkg::axi_data_t d;
      axi_pkg::b_chan_t   eb;
      axi_pkg::r_chan_t   er;
      eb.id    = 4'd9;
      eb.resp  = ref_access(1'b1, addr, 4'd0, 3'd2, data, d);
      er.resp  = ref_access(1'b0, addr, 4'd0, 3'd2, '0, d);
      er.id    = 4'd10;
      er.data  = d;
      er.last  = 1'b1;
      exp_b.push_back(eb);
      exp_r.push_back(er);
      @(negedge axi);
      aw       = '{id: 4'd9, addr: addr, len: 4'd0, size: 3'd2};
      ar       = '{id: 4'd10, addr: addr, len: 4'd0, size: 3'd2};
      aw_valid = 1'b1;
      ar_valid = 1'b1;
      finish_aw();
      w       = '{id: 4'd9, data: data};
      w_valid = 1'b1;
      finish_w();
      finish_ar();
      wait_responses();
   endtask

   task automatic random_mem_ops(input int n);
      int unsigned        idx;
      axi_pkg::axi_addr_t addr;
      for (int i = 0; i < n; i++) begin
         idx  = $urandom_range(0, 15);   // small window so reads hit written words
         addr = sys_bus_pkg::mem_base + (axi_pkg::axi_addr_t'(idx) << 2);
         if ($urandom_range(0, 1) == 1)
            do_write(axi_pkg::axi_id_t'($urandom_range(0, 15)), addr, $urandom());
         else
            do_read(axi_pkg::axi_id_t'($urandom_range(0, 15)), addr);
      end
   endtask

   //////////////////////////////////////////////////
   // response ready, random stretches when enabled

   always @(negedge axi) begin
      if (!stall_en) begin
         ready_state = 1'b1;
      end else if (stall_left == 0) begin
         ready_state = ~ready_state;
         stall_left  = $urandom_range(1, 6);
      end else begin
         stall_left--;
      end
      b_ready = ready_state;
      r_ready = ready_state;
   end

   //////////////////////////////////////////////////
   // compare process, every b and r beat

   always @(posedge axi) begin
      axi_pkg::b_chan_t eb;
      axi_pkg::r_chan_t er;
      if (!reset) begin
         if (b_held) begin                      // stalled beat must stay put
            if (b_valid !== 1'b1) report_failure("b_valid dropped while b_ready was low");
            check_id("b.id (held)", b.id, b_prev.id);
            check_resp("b.resp (held)", b.resp, b_prev.resp);
         end
         if (r_held) begin
            if (r_valid !== 1'b1) report_failure("r_valid dropped while r_ready was low");
            check_id("r.id (held)", r.id, r_prev.id);
            check_data("r.data (held)", r.data, r_prev.data);
            check_resp("r.resp (held)", r.resp, r_prev.resp);
         end
         if (b_valid && b_ready) begin
            if (exp_b.size() == 0) report_failure("write response with no write outstanding");
            eb = exp_b.pop_front();
            check_id("b.id", b.id, eb.id);
            check_resp("b.resp", b.resp, eb.resp);
         end
         if (r_valid && r_ready) begin
            if (exp_r.size() == 0) report_failure("read response with no read outstanding");
            er = exp_r.pop_front();
            check_id("r.id", r.id, er.id);
            check_data("r.data", r.data, er.data);
            check_resp("r.resp", r.resp, er.resp);
            if (r.last !== 1'b1) report_failure("r.last was low on a single beat read");
         end
         b_held = b_valid && !b_ready;
         r_held = r_valid && !r_ready;
         b_prev = b;
         r_prev = r;
      end
   end

   // run limit
   always @(posedge axi) begin
      cycle_cnt++;
      if (cycle_cnt >= max_cycles)
         report_failure("timeout, the tests did not finish within 20000 clock cycles");
   end

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      void'($urandom(13762));
      for (int i = 0; i < sys_bus_pkg::mem_words; i++) mem_m[i] = '0;   // memory resets to zero
      scratch_m = '0;
      wait_m    = '0;
      reset    = 1'b1;
      aw       = '0;
      w        = '0;
      ar       = '0;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      ar_valid = 1'b0;
      b_ready  = 1'b1;
      r_ready  = 1'b1;
      repeat (5) @(posedge axi);
      @(negedge axi);
      reset = 1'b0;

      // id word and scratch
      do_read(4'd3, 32'h0);
      do_write(4'd5, 32'h4, 32'h1234_ABCD);
      do_read(4'd6, 32'h4);

      // memory at several wait settings
      do_write(4'd1, 32'h8, 32'd0);
      random_mem_ops(24);
      do_write(4'd1, 32'h8, 32'd3);
      do_read(4'd2, 32'h8);
      random_mem_ops(24);
      do_write(4'd1, 32'h8, 32'd7);
      random_mem_ops(24);
      do_write(4'd1, 32'h8, 32'hFFFF_FFFF);   // only low 4 bits land
      do_read(4'd2, 32'h8);
      random_mem_ops(24);

      // unmapped, ends in the bridge timeout
      do_write(4'd7, 32'h2000, 32'hDEAD_BEEF);
      do_read(4'd8, 32'h2000);

      // bursts and narrow sizes
      do_write(4'd4, sys_bus_pkg::mem_base + 32'h14, 32'hAAAA_5555, 4'd1, 3'd2);
      do_write(4'd4, sys_bus_pkg::mem_base + 32'h14, 32'h5555_AAAA, 4'd0, 3'd1);
      do_read(4'd4, sys_bus_pkg::mem_base + 32'h14, 4'd3, 3'd2);
      do_read(4'd4, sys_bus_pkg::mem_base + 32'h14, 4'd0, 3'd0);
      do_read(4'd4, sys_bus_pkg::mem_base + 32'h14);

      // simultaneous write and read to one word
      write_read_race(sys_bus_pkg::mem_base + 32'h20, 32'hC0DE_0020);

      // response back-pressure
      stall_en = 1'b1;
      random_mem_ops(30);
      do_read(4'd12, 32'h4);
      stall_en = 1'b0;

      repeat (4) @(negedge axi);
      // bridge back in idle, nothing left on b or r
      if (aw_ready && ar_ready && !b_valid && !r_valid) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         report_failure("bridge did not return to idle at the end of the run");
      end
   end

endmodule

// ==== verilog/axi_sys_top.sv ====
//////////////////////////////////////////////////
// axi register subsystem top
// bridge, decoder, config block and wait memory
//////////////////////////////////////////////////

module axi_sys_top (
   input  logic              axi,
   input  logic              reset,
   input  axi_pkg::aw_chan_t aw,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  axi_pkg::w_chan_t  w,
   input  logic              w_valid,
   output logic              w_ready,
   output axi_pkg::b_chan_t  b,
   output logic              b_valid,
   input  logic              b_ready,
   input  axi_pkg::ar_chan_t ar,
   input  logic              ar_valid,
   output logic              ar_ready,
   output axi_pkg::r_chan_t  r,
   output logic              r_valid,
   input  logic              r_ready
);

   sys_bus_pkg::sys_req_t  bus_req, cfg_req, mem_req;
   sys_bus_pkg::sys_rsp_t  bus_rsp, cfg_rsp, mem_rsp;
   sys_bus_pkg::mem_wait_t mem_wait;   // config -> memory latency

   axi_sys_bridge u_bridge (
      .axi, .reset,
      .aw, .aw_valid, .aw_ready,
      .w,  .w_valid,  .w_ready,
      .b,  .b_valid,  .b_ready,
      .ar, .ar_valid, .ar_ready,
      .r,  .r_valid,  .r_ready,
      .req (bus_req),
      .rsp (bus_rsp)
   );

   sys_bus_decoder u_decoder (
      .axi, .reset,
      .req (bus_req), .rsp (bus_rsp),
      .cfg_req, .cfg_rsp,
      .mem_req, .mem_rsp
   );

   sys_config_regs u_config (
      .axi, .reset,
      .req (cfg_req), .rsp (cfg_rsp),
      .mem_wait
   );

   sys_wait_mem u_mem (
      .axi, .reset,
      .req (mem_req), .rsp (mem_rsp),
      .mem_wait
   );

endmodule

// ==== verilog/sys_wait_mem.sv ====
//////////////////////////////////////////////////
// wait state memory
// word array on the system bus, ack comes
// mem_wait + 1 cycles after the strobe
//////////////////////////////////////////////////

module sys_wait_mem (
   input  logic                   axi,
   input  logic                   reset,
   input  sys_bus_pkg::sys_req_t  req,
   input  sys_bus_pkg::mem_wait_t mem_wait,
   output sys_bus_pkg::sys_rsp_t  rsp
);

   sys_bus_pkg::sys_data_t mem [sys_bus_pkg::mem_words];

   logic [sys_bus_pkg::mem_idx_w-1:0] idx;

   sys_bus_pkg::mem_wait_t wait_cnt;   // cycles left before ack
   logic                   busy;
   sys_bus_pkg::sys_data_t rdata_q;

   assign idx = req.addr[sys_bus_pkg::mem_idx_w+1:2];

   //////////////////////////////////////////////////
   // array, written at the strobe

   always_ff @(posedge axi) begin
      if (reset) begin
         for (int i = 0; i < sys_bus_pkg::mem_words; i++) begin
            mem[i] <= '0;
         end
      end else if (req.wen) begin
         mem[idx] <= req.wdata;
      end
   end

   // read word taken at the strobe, held until ack
   always_ff @(posedge axi) begin
      if (req.ren) rdata_q <= mem[idx];
   end

   //////////////////////////////////////////////////
   // latency counter

   always_ff @(posedge axi) begin
      if (reset) begin
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (req.wen || req.ren) begin
         busy     <= 1'b1;
         wait_cnt <= mem_wait;   // sampled once per access
      end else if (busy) begin
         if (wait_cnt == '0) begin
            busy <= 1'b0;        // ack cycle
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

   assign rsp.ack   = busy && (wait_cnt == '0);
   assign rsp.rdata = rdata_q;

endmodule

// ==== verilog/sys_config_regs.sv ====
//////////////////////////////////////////////////
// configuration registers
// word 0 id (ro), word 1 scratch, word 2 memory
// wait setting, word 3 reads zero
// ack one cycle after the strobe
//////////////////////////////////////////////////

module sys_config_regs (
   input  logic                   axi,
   input  logic                   reset,
   input  sys_bus_pkg::sys_req_t  req,
   output sys_bus_pkg::sys_rsp_t  rsp,
   output sys_bus_pkg::mem_wait_t mem_wait
);

   logic [sys_bus_pkg::cfg_idx_w-1:0] word;

   sys_bus_pkg::sys_data_t scratch_q;
   sys_bus_pkg::mem_wait_t mem_wait_q;
   sys_bus_pkg::sys_data_t rdata_q;
   logic                   ack_q;

   assign word = req.addr[sys_bus_pkg::cfg_idx_w+1:2];   // word aligned

   //////////////////////////////////////////////////
   // register writes

   always_ff @(posedge axi) begin
      if (reset) begin
         scratch_q  <= '0;
         mem_wait_q <= '0;
      end else if (req.wen) begin
         case (word)
            2'd1:    scratch_q  <= req.wdata;
            2'd2:    mem_wait_q <= req.wdata[sys_bus_pkg::mem_wait_w-1:0];
            default: ;   // id and word 3 ignore writes, still acked
         endcase
      end
   end

   //////////////////////////////////////////////////
   // read mux and ack

   always_ff @(posedge axi) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req.wen || req.ren;
      end
   end

   always_ff @(posedge axi) begin
      if (req.ren) begin
         case (word)
            2'd0:    rdata_q <= sys_bus_pkg::cfg_id_value;
            2'd1:    rdata_q <= scratch_q;
            2'd2:    rdata_q <= sys_bus_pkg::sys_data_t'(mem_wait_q);   // upper bits zero
            default: rdata_q <= '0;
         endcase
      end
   end

   assign rsp      = '{rdata: rdata_q, ack: ack_q};
   assign mem_wait = mem_wait_q;

endmodule

// ==== verilog/sys_bus_decoder.sv ====
//////////////////////////////////////////////////
// system bus decoder
// gates the strobes by address region and merges
// the target acks and read data
//////////////////////////////////////////////////

module sys_bus_decoder (
   input  logic                  axi,
   input  logic                  reset,
   input  sys_bus_pkg::sys_req_t req,
   output sys_bus_pkg::sys_rsp_t rsp,
   output sys_bus_pkg::sys_req_t cfg_req,
   input  sys_bus_pkg::sys_rsp_t cfg_rsp,
   output sys_bus_pkg::sys_req_t mem_req,
   input  sys_bus_pkg::sys_rsp_t mem_rsp
);

   sys_bus_pkg::sys_addr_t cfg_off, mem_off;
   logic cfg_hit, mem_hit;
   logic mem_sel_q;   // region of the last strobe

   // offset below base wraps to a large value and misses
   assign cfg_off = req.addr - sys_bus_pkg::cfg_base;
   assign mem_off = req.addr - sys_bus_pkg::mem_base;
   assign cfg_hit = cfg_off < sys_bus_pkg::sys_addr_t'(sys_bus_pkg::cfg_words * 4);
   assign mem_hit = mem_off < sys_bus_pkg::sys_addr_t'(sys_bus_pkg::mem_words * 4);

   // addr and wdata pass, strobes only to the hit region
   assign cfg_req = '{addr: req.addr, wdata: req.wdata,
                      wen: req.wen && cfg_hit, ren: req.ren && cfg_hit};
   assign mem_req = '{addr: req.addr, wdata: req.wdata,
                      wen: req.wen && mem_hit, ren: req.ren && mem_hit};

   always_ff @(posedge axi) begin
      if (reset) begin
         mem_sel_q <= 1'b0;
      end else if (req.wen || req.ren) begin
         mem_sel_q <= mem_hit;
      end
   end

   // unmapped -> no ack at all, bridge times out
   assign rsp.ack   = cfg_rsp.ack || mem_rsp.ack;
   assign rsp.rdata = mem_sel_q ? mem_rsp.rdata : cfg_rsp.rdata;

endmodule

// ==== verilog/axi_sys_bridge.sv ====
//////////////////////////////////////////////////
// axi to system bus bridge
// takes one single beat axi transaction at a time,
// turns it into a wen/ren strobe and waits for ack
// bursts and non word sizes get slverr, no strobe
// a missing ack ends in slverr after the timeout
//////////////////////////////////////////////////

module axi_sys_bridge (
   input  logic                  axi,
   input  logic                  reset,
   // write address / data / response
   input  axi_pkg::aw_chan_t     aw,
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  axi_pkg::w_chan_t      w,
   input  logic                  w_valid,
   output logic                  w_ready,
   output axi_pkg::b_chan_t      b,
   output logic                  b_valid,
   input  logic                  b_ready,
   // read address / data
   input  axi_pkg::ar_chan_t     ar,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   output axi_pkg::r_chan_t      r,
   output logic                  r_valid,
   input  logic                  r_ready,
   // system bus master side
   output sys_bus_pkg::sys_req_t req,
   input  sys_bus_pkg::sys_rsp_t rsp
);

   typedef enum logic [2:0] {
      st_idle,    // waiting for aw or ar
      st_wdata,   // aw taken, waiting for the w beat
      st_wwait,   // wen issued, waiting for ack
      st_rwait,   // ren issued, waiting for ack
      st_resp     // b or r valid, waiting for ready
   } state_t;

   state_t state;

   // latched transaction
   axi_pkg::axi_id_t      id_q;
   sys_bus_pkg::sys_addr_t addr_q;
   sys_bus_pkg::sys_data_t data_q;
   logic                  err_q;    // unsupported access
   axi_pkg::axi_data_t    rdata_q;
   axi_pkg::axi_resp_t    resp_q;

   logic wen_q, ren_q;

   logic [sys_bus_pkg::ack_cnt_w-1:0] ack_cnt;

   logic aw_err, ar_err;
   logic aw_hs, ar_hs, w_hs;
   logic waiting, timeout, done, ack_ok, resp_hs;

   //////////////////////////////////////////////////
   // handshakes and access checks

   assign aw_err = (aw.len != axi_pkg::len_single) || (aw.size != axi_pkg::size_word);
   assign ar_err = (ar.len != axi_pkg::len_single) || (ar.size != axi_pkg::size_word);

   assign aw_ready = (state == st_idle);
   assign ar_ready = (state == st_idle) && !aw_valid;   // write wins
   assign w_ready  = (state == st_wdata);

   assign aw_hs = aw_valid && aw_ready;
   assign ar_hs = ar_valid && ar_ready;
   assign w_hs  = w_valid && w_ready;

   assign waiting = (state == st_wwait) || (state == st_rwait);
   assign timeout = waiting && (ack_cnt == sys_bus_pkg::ack_cnt_w'(sys_bus_pkg::ack_timeout));
   assign ack_ok  = rsp.ack && !err_q;     // real target answer
   // error counts as an immediate ack, no strobe went out
   assign done    = waiting && (err_q || rsp.ack || timeout);
   assign resp_hs = (b_valid && b_ready) || (r_valid && r_ready);

   //////////////////////////////////////////////////
   // control fsm

   always_ff @(posedge axi) begin
      if (reset) begin
         state   <= st_idle;
         wen_q   <= 1'b0;
         ren_q   <= 1'b0;
         b_valid <= 1'b0;
         r_valid <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         wen_q <= 1'b0;   // strobes are single cycle
         ren_q <= 1'b0;
         case (state)
            st_idle: begin
               if (aw_hs) begin
                  err_q <= aw_err;
                  state <= st_wdata;
               end else if (ar_hs) begin
                  err_q <= ar_err;
                  ren_q <= !ar_err;
                  state <= st_rwait;
               end
            end
            st_wdata: begin
               if (w_hs) begin
                  wen_q <= !err_q;   // bad write still eats its beat
                  state <= st_wwait;
               end
            end
            st_wwait: begin
               if (done) begin
                  b_valid <= 1'b1;
                  state   <= st_resp;
               end
            end
            st_rwait: begin
               if (done) begin
                  r_valid <= 1'b1;
                  state   <= st_resp;
               end
            end
            st_resp: begin
               // held under back-pressure
               if (resp_hs) begin
                  b_valid <= 1'b0;
                  r_valid <= 1'b0;
                  state   <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // timeout counter, zero at the strobe cycle

   always_ff @(posedge axi) begin
      if (reset || !waiting) begin
         ack_cnt <= '0;
      end else if (!timeout) begin
         ack_cnt <= ack_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // payload

   always_ff @(posedge axi) begin
      if (aw_hs) begin
         id_q   <= aw.id;
         addr_q <= aw.addr;
      end else if (ar_hs) begin
         id_q   <= ar.id;
         addr_q <= ar.addr;
      end
      if (w_hs) data_q <= w.data;
      if (done) begin
         resp_q  <= ack_ok ? axi_pkg::resp_okay : axi_pkg::resp_slverr;
         rdata_q <= ack_ok ? rsp.rdata : '0;   // zero on error or timeout
      end
   end

   assign req = '{addr: addr_q, wdata: data_q, wen: wen_q, ren: ren_q};

   assign b = '{id: id_q, resp: resp_q};
   assign r = '{id: id_q, data: rdata_q, resp: resp_q, last: 1'b1};   // always one beat

endmodule

// ==== verilog/sys_bus_pkg.sv ====
//////////////////////////////////////////////////
// system bus definitions
// strobe/ack request and response structs,
// address map and bridge timeout
//////////////////////////////////////////////////

package sys_bus_pkg;

   typedef logic [31:0] sys_addr_t;
   typedef logic [31:0] sys_data_t;

   // one cycle wen/ren strobe, addr and wdata held by the master
   typedef struct packed {
      sys_addr_t addr;
      sys_data_t wdata;
      logic      wen;
      logic      ren;
   } sys_req_t;

   // ack is a one cycle pulse, rdata valid with it
   typedef struct packed {
      sys_data_t rdata;
      logic      ack;
   } sys_rsp_t;

   //////////////////////////////////////////////////
   // bridge guard

   localparam int unsigned ack_timeout = 32;   // cycles after the strobe
   localparam int unsigned ack_cnt_w   = $clog2(ack_timeout + 1);

   //////////////////////////////////////////////////
   // address map

   localparam sys_addr_t   cfg_base  = 32'h0000_0000;
   localparam int unsigned cfg_words = 4;
   localparam int unsigned cfg_idx_w = $clog2(cfg_words);
   localparam sys_addr_t   mem_base  = 32'h0000_1000;
   localparam int unsigned mem_words = 256;
   localparam int unsigned mem_idx_w = $clog2(mem_words);

   localparam sys_data_t   cfg_id_value = 32'h5A5A_0001;

   localparam int unsigned mem_wait_w = 4;
   typedef logic [mem_wait_w-1:0] mem_wait_t;

endpackage

// ==== verilog/axi_pkg.sv ====
//////////////////////////////////////////////////
// axi definitions
// widths, response codes and channel payload
// structs for the single beat AXI3 slave port
//////////////////////////////////////////////////

package axi_pkg;

   //////////////////////////////////////////////////
   // widths

   localparam int unsigned id_w   = 4;
   localparam int unsigned addr_w = 32;
   localparam int unsigned data_w = 32;
   localparam int unsigned len_w  = 4;   // axi3 burst length field
   localparam int unsigned size_w = 3;

   typedef logic [id_w-1:0]   axi_id_t;
   typedef logic [addr_w-1:0] axi_addr_t;
   typedef logic [data_w-1:0] axi_data_t;
   typedef logic [len_w-1:0]  axi_len_t;
   typedef logic [size_w-1:0] axi_size_t;
   typedef logic [1:0]        axi_resp_t;

   //////////////////////////////////////////////////
   // response codes and legal transfer shape

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   localparam axi_size_t size_word = 3'd2;   // 4 bytes per beat
   localparam axi_len_t  len_single = 4'd0;  // one beat, no burst

   //////////////////////////////////////////////////
   // channel payloads, valid/ready travel beside them

   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } aw_chan_t;

   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } ar_chan_t;

   typedef struct packed {
      axi_id_t   id;    // wid, axi3 only
      axi_data_t data;
   } w_chan_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } b_chan_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } r_chan_t;

endpackage
